//--- compile.f
+incdir+.
isaPkg.sv
busPkg.sv
registerFile.sv
controlUnit.sv
alu.sv
programCounter.sv
requestUnit.sv
datapath.sv
datapathTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f compile.f --top-module datapathTb -o simv
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "TESTS PASSED" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0

//--- datapathTb.sv
`timescale 1ns/10ps
`include "core_params.svh"

module datapathTb;

    localparam int TESTS = 4;
    localparam int MAX_STORES = 16;
    localparam logic [31:0] RESULT_BASE = 32'h0000_0300;
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] OP_LOAD = 7'b0000011;
    localparam logic [6:0] OP_JALR = 7'b1100111;

    logic clk;
    logic rstN;
    logic iAck;
    logic dAck;
    logic [31:0] instruction;
    logic [`XLEN-1:0] memLoad;
    logic [`XLEN-1:0] iAddress;
    logic [`XLEN-1:0] dAddress;
    logic [`XLEN-1:0] memStore;
    logic dataRead;
    logic dataWrite;

    logic [31:0] mem [256];
    logic [31:0] lfsrState;
    int startIdx [TESTS];
    int storeCount [TESTS];
    logic [31:0] expData [TESTS][MAX_STORES];
    string testName [TESTS];
    int curTest;
    int storeIdx;
    int errors;
    int passCount;
    int failCount;
    int at;

    // Memory model state.
    logic iBusy;
    logic dBusy;
    logic lastIAck;
    logic [1:0] iWait;
    logic [1:0] dWait;
    logic [31:0] heldIAddr;
    logic [31:0] heldDAddr;
    logic [31:0] heldStore;
    logic heldWrite;

    datapath datapath_i (
        .clk         (clk),
        .rstN        (rstN),
        .iAck        (iAck),
        .dAck        (dAck),
        .instruction (instruction),
        .memLoad     (memLoad),
        .iAddress    (iAddress),
        .dAddress    (dAddress),
        .memStore    (memStore),
        .dataRead    (dataRead),
        .dataWrite   (dataWrite)
    );

    always begin
        clk = 1'b0;
        #50;
        clk = 1'b1;
        #50;
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1.
    function automatic logic lfsrBit();
        logic fb;
        fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], fb};
        return fb;
    endfunction

    function automatic logic [1:0] randDelay();
        logic hi;
        logic lo;
        hi = lfsrBit();
        lo = lfsrBit();
        return {hi, lo};
    endfunction

    function automatic logic [31:0] encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encR(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encSw(logic [11:0] off, logic [4:0] rs2, logic [4:0] rs1);
        return {off[11:5], rs2, rs1, 3'b010, off[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] encB(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                         logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] encJal(logic [4:0] rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] encLui(logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    task automatic emit(logic [31:0] word);
        mem[at] = word;
        at++;
    endtask

    task automatic expectStore(int t, logic [31:0] value);
        expData[t][storeCount[t]] = value;
        storeCount[t]++;
    endtask

    task automatic beginTest(int t, string name);
        startIdx[t] = at;
        storeCount[t] = 0;
        testName[t] = name;
        emit(encI(12'h300, 5'd0, 3'b000, 5'd10, OP_IMM));
    endtask

    task automatic loadPrograms();
        int f3s [12];
        int rsA [12];
        int rsB [12];
        int jalAt;
        int jalrAt;
        // Unused words hold a no-op opcode tagged with their own address.
        for (int i = 0; i < 256; i++) begin
            mem[i] = {17'h0, 8'(i), 7'b0001011};
        end
        at = 1;
        beginTest(0, "alu operations");
        emit(encI(12'd100, 5'd0, 3'b000, 5'd1, OP_IMM));
        emit(encI(12'hff9, 5'd0, 3'b000, 5'd2, OP_IMM));
        emit(encR(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        emit(encR(7'h20, 5'd1, 5'd2, 3'b000, 5'd4));
        emit(encR(7'h00, 5'd2, 5'd1, 3'b100, 5'd5));
        emit(encR(7'h00, 5'd2, 5'd1, 3'b110, 5'd6));
        emit(encR(7'h00, 5'd2, 5'd1, 3'b111, 5'd7));
        emit(encI(12'h004, 5'd1, 3'b001, 5'd8, OP_IMM));
        emit(encI(12'h401, 5'd2, 3'b101, 5'd9, OP_IMM));
        emit(encI(12'h01c, 5'd2, 3'b101, 5'd11, OP_IMM));
        emit(encR(7'h00, 5'd1, 5'd2, 3'b010, 5'd12));
        emit(encR(7'h00, 5'd1, 5'd2, 3'b011, 5'd13));
        emit(encI(12'd55, 5'd0, 3'b000, 5'd0, OP_IMM));
        emit(encLui(5'd14, 20'h12345));
        emit(encI(12'h700, 5'd1, 3'b110, 5'd15, OP_IMM));
        emit(encI(12'h0f0, 5'd2, 3'b111, 5'd16, OP_IMM));
        for (int k = 0; k < 14; k++) begin
            emit(encSw(12'(4 * k), 5'(k + 3), 5'd10));
        end
        emit(encSw(12'd56, 5'd0, 5'd10));
        emit(encJal(5'd0, 21'd0));
        // Registers x3..x16 in order, then x0 after a write to it.
        expectStore(0, 32'h0000_005d);
        expectStore(0, 32'hffff_ff95);
        expectStore(0, 32'hffff_ff9d);
        expectStore(0, 32'hffff_fffd);
        expectStore(0, 32'h0000_0060);
        expectStore(0, 32'h0000_0640);
        expectStore(0, 32'hffff_fffc);
        expectStore(0, 32'h0000_0300);
        expectStore(0, 32'h0000_000f);
        expectStore(0, 32'h0000_0001);
        expectStore(0, 32'h0000_0000);
        expectStore(0, 32'h1234_5000);
        expectStore(0, 32'h0000_0764);
        expectStore(0, 32'h0000_00f0);
        expectStore(0, 32'h0000_0000);

        beginTest(1, "load and store");
        emit(encLui(5'd1, 20'hcafeb));
        emit(encSw(12'd0, 5'd1, 5'd10));
        emit(encI(12'd0, 5'd10, 3'b010, 5'd2, OP_LOAD));
        emit(encSw(12'd4, 5'd2, 5'd10));
        emit(encI(12'd1, 5'd2, 3'b000, 5'd3, OP_IMM));
        emit(encSw(12'd8, 5'd3, 5'd10));
        emit(encJal(5'd0, 21'd0));
        expectStore(1, 32'hcafe_b000);
        expectStore(1, 32'hcafe_b000);
        expectStore(1, 32'hcafe_b001);

        // Marker 1 means the branch was taken, 2 that it fell through.
        beginTest(2, "branches");
        f3s = '{0, 0, 1, 1, 4, 4, 5, 5, 6, 6, 7, 7};
        rsA = '{2, 1, 1, 2, 1, 2, 2, 1, 2, 1, 1, 2};
        rsB = '{2, 2, 2, 2, 2, 1, 1, 2, 1, 2, 2, 1};
        emit(encI(12'hfff, 5'd0, 3'b000, 5'd1, OP_IMM));
        emit(encI(12'd1, 5'd0, 3'b000, 5'd2, OP_IMM));
        for (int k = 0; k < 12; k++) begin
            emit(encI(12'd1, 5'd0, 3'b000, 5'd5, OP_IMM));
            emit(encB(3'(f3s[k]), 5'(rsA[k]), 5'(rsB[k]), 13'd8));
            emit(encI(12'd2, 5'd0, 3'b000, 5'd5, OP_IMM));
            emit(encSw(12'(4 * k), 5'd5, 5'd10));
            expectStore(2, (k % 2 == 0) ? 32'd1 : 32'd2);
        end
        emit(encJal(5'd0, 21'd0));

        beginTest(3, "jal and jalr");
        jalAt = at;
        emit(encJal(5'd1, 21'd12));
        emit(encI(12'd99, 5'd0, 3'b000, 5'd5, OP_IMM));
        emit(encI(12'd98, 5'd0, 3'b000, 5'd5, OP_IMM));
        emit(encSw(12'd0, 5'd1, 5'd10));
        jalrAt = at + 1;
        // Target plus offset is odd so that bit 0 gets cleared.
        emit(encI(12'(jalrAt * 4 + 4), 5'd0, 3'b000, 5'd6, OP_IMM));
        emit(encI(12'd5, 5'd6, 3'b000, 5'd7, OP_JALR));
        emit(encI(12'd97, 5'd0, 3'b000, 5'd5, OP_IMM));
        emit(encSw(12'd4, 5'd7, 5'd10));
        emit(encSw(12'd8, 5'd5, 5'd10));
        emit(encJal(5'd0, 21'd0));
        expectStore(3, 32'(jalAt * 4 + 4));
        expectStore(3, 32'(jalrAt * 4 + 4));
        expectStore(3, 32'd0);
    endtask

    task automatic checkStore();
        logic [31:0] expAddr;
        expAddr = RESULT_BASE + 32'(4 * storeIdx);
        if (storeIdx >= storeCount[curTest]) begin
            $display("Error at %0t: store beyond the end of test %0d", $time, curTest);
            errors++;
        end else begin
            if (dAddress !== expAddr) begin
                $display("Mismatch at %0t: dAddress expected %h got %h",
                         $time, expAddr, dAddress);
                errors++;
            end
            if (memStore !== expData[curTest][storeIdx]) begin
                $display("Mismatch at %0t: memStore expected %h got %h",
                         $time, expData[curTest][storeIdx], memStore);
                errors++;
            end
        end
        storeIdx++;
    endtask

    // Shared instruction and data memory with random acknowledge delays.
    always @(negedge clk) begin
        iAck = 1'b0;
        dAck = 1'b0;
        if (!rstN) begin
            iBusy = 1'b0;
            dBusy = 1'b0;
            lastIAck = 1'b0;
        end else if (dataRead || dataWrite) begin
            if (!dBusy) begin
                if (!lastIAck) begin
                    $display("Error at %0t: data strobe rose without a fetch ack", $time);
                    errors++;
                end
                dBusy = 1'b1;
                dWait = randDelay();
                heldDAddr = dAddress;
                heldStore = memStore;
                heldWrite = dataWrite;
            end else begin
                if (dAddress !== heldDAddr) begin
                    $display("Mismatch at %0t: dAddress expected %h got %h",
                             $time, heldDAddr, dAddress);
                    errors++;
                end
                if (memStore !== heldStore) begin
                    $display("Mismatch at %0t: memStore expected %h got %h",
                             $time, heldStore, memStore);
                    errors++;
                end
                if (dataWrite !== heldWrite) begin
                    $display("Mismatch at %0t: dataWrite expected %b got %b",
                             $time, heldWrite, dataWrite);
                    errors++;
                end
            end
            lastIAck = 1'b0;
            if (dWait == 2'd0) begin
                dAck = 1'b1;
                dBusy = 1'b0;
                if (dataWrite) begin
                    mem[dAddress[9:2]] = memStore;
                    checkStore();
                end else begin
                    memLoad = mem[dAddress[9:2]];
                end
            end else begin
                dWait = dWait - 2'd1;
            end
        end else begin
            if (!iBusy) begin
                iBusy = 1'b1;
                iWait = randDelay();
                heldIAddr = iAddress;
            end else if (iAddress !== heldIAddr) begin
                $display("Mismatch at %0t: iAddress expected %h got %h",
                         $time, heldIAddr, iAddress);
                errors++;
            end
            lastIAck = 1'b0;
            if (iWait == 2'd0) begin
                iAck = 1'b1;
                iBusy = 1'b0;
                lastIAck = 1'b1;
            end else begin
                iWait = iWait - 2'd1;
            end
        end
        instruction = mem[iAddress[9:2]];
    end

    initial begin
        #(TESTS * 60 * 8 * 100 + TESTS * 1200);
        $display("Error: no store arrived in time, test %0d stalled", curTest);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int errBefore;
        rstN = 1'b0;
        iAck = 1'b0;
        dAck = 1'b0;
        instruction = '0;
        memLoad = '0;
        lfsrState = 32'h5ac4;
        errors = 0;
        passCount = 0;
        failCount = 0;
        curTest = 0;
        storeIdx = 0;
        loadPrograms();
        for (int t = 0; t < TESTS; t++) begin
            @(negedge clk);
            rstN = 1'b0;
            curTest = t;
            storeIdx = 0;
            errBefore = errors;
            // Word 0 jumps to the start of the current program.
            mem[0] = encJal(5'd0, 21'(startIdx[t] * 4));
            repeat (10) @(negedge clk);
            rstN = 1'b1;
            if (iAddress !== `RESET_PC) begin
                $display("Mismatch at %0t: iAddress expected %h got %h",
                         $time, `RESET_PC, iAddress);
                errors++;
            end
            if (dataRead !== 1'b0 || dataWrite !== 1'b0) begin
                $display("Error at %0t: data strobe high after reset", $time);
                errors++;
            end
            while (storeIdx < storeCount[t]) begin
                @(negedge clk);
            end
            repeat (4) @(negedge clk);
            if (errors == errBefore) begin
                passCount++;
                $display("Test %0d (%s): pass", t, testName[t]);
            end else begin
                failCount++;
                $display("Test %0d (%s): fail", t, testName[t]);
            end
        end
        $display("Passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- datapath.sv
`timescale 1ns/10ps

module datapath (
    input  logic          clk,
    input  logic          rstN,
    input  logic          iAck,
    input  logic          dAck,
    input  isaPkg::instrT instruction,
    input  busPkg::wordT  memLoad,
    output busPkg::addrT  iAddress,
    output busPkg::addrT  dAddress,
    output busPkg::wordT  memStore,
    output logic          dataRead,
    output logic          dataWrite
);

    isaPkg::regIdxT readIdxA;
    isaPkg::regIdxT readIdxB;
    isaPkg::regIdxT writeIdx;
    busPkg::wordT   imm;
    isaPkg::aluOpT  aluOp;
    logic           aluSrcImm;
    logic           regWrite;
    logic           memRead;
    logic           memWrite;
    logic           memToReg;
    logic           branch;
    logic           jal;
    logic           jalr;
    logic           branchTaken;
    logic           commit;
    busPkg::addrT   pc;
    busPkg::wordT   pcPlus4;
    busPkg::wordT   readDataA;
    busPkg::wordT   readDataB;
    busPkg::wordT   aluSrcB;
    busPkg::wordT   aluResult;
    busPkg::wordT   writeBack;

    assign pcPlus4 = pc + busPkg::wordT'(4);

    registerFile registerFile_i (
        .clk       (clk),
        .rstN      (rstN),
        .writeEn   (regWrite && commit),
        .readIdxA  (readIdxA),
        .readIdxB  (readIdxB),
        .writeIdx  (writeIdx),
        .writeData (writeBack),
        .readDataA (readDataA),
        .readDataB (readDataB)
    );

    controlUnit controlUnit_i (
        .instruction (instruction),
        .readIdxA    (readIdxA),
        .readIdxB    (readIdxB),
        .writeIdx    (writeIdx),
        .imm         (imm),
        .aluOp       (aluOp),
        .aluSrcImm   (aluSrcImm),
        .regWrite    (regWrite),
        .memRead     (memRead),
        .memWrite    (memWrite),
        .memToReg    (memToReg),
        .branch      (branch),
        .jal         (jal),
        .jalr        (jalr)
    );

    assign aluSrcB = aluSrcImm ? imm : readDataB;

    alu alu_i (
        .srcA        (readDataA),
        .srcB        (aluSrcB),
        .aluOp       (aluOp),
        .funct3      (instruction[14:12]),
        .result      (aluResult),
        .branchTaken (branchTaken)
    );

    // Loads return memory data and jumps link the return address.
    always_comb begin
        if (memToReg) begin
            writeBack = memLoad;
        end else if (jal || jalr) begin
            writeBack = pcPlus4;
        end else begin
            writeBack = aluResult;
        end
    end

    programCounter programCounter_i (
        .clk         (clk),
        .rstN        (rstN),
        .commit      (commit),
        .branch      (branch),
        .branchTaken (branchTaken),
        .jal         (jal),
        .jalr        (jalr),
        .imm         (imm),
        .jalrTarget  (aluResult),
        .pc          (pc)
    );

    requestUnit requestUnit_i (
        .clk        (clk),
        .rstN       (rstN),
        .iAck       (iAck),
        .dAck       (dAck),
        .pc         (pc),
        .memAddress (aluResult),
        .storeData  (readDataB),
        .memRead    (memRead),
        .memWrite   (memWrite),
        .iAddress   (iAddress),
        .dAddress   (dAddress),
        .memStore   (memStore),
        .dataRead   (dataRead),
        .dataWrite  (dataWrite),
        .commit     (commit)
    );

endmodule

//--- requestUnit.sv
`timescale 1ns/10ps

module requestUnit (
    input  logic         clk,
    input  logic         rstN,
    input  logic         iAck,
    input  logic         dAck,
    input  busPkg::addrT pc,
    input  busPkg::addrT memAddress,
    input  busPkg::wordT storeData,
    input  logic         memRead,
    input  logic         memWrite,
    output busPkg::addrT iAddress,
    output busPkg::addrT dAddress,
    output busPkg::wordT memStore,
    output logic         dataRead,
    output logic         dataWrite,
    output logic         commit
);

    busPkg::reqStateT state;
    logic             isMem;
    logic             startData;

    assign isMem     = memRead || memWrite;
    assign startData = (state == busPkg::reqFetch) && iAck && isMem;

    // The fetch address follows the PC, which only moves on commit.
    assign iAddress = pc;

    // The core is frozen whenever commit is low.
    assign commit = ((state == busPkg::reqFetch) && iAck && !isMem) ||
                    ((state == busPkg::reqData) && dAck);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= busPkg::reqFetch;
            dataRead  <= 1'b0;
            dataWrite <= 1'b0;
        end else if (startData) begin
            state     <= busPkg::reqData;
            dataRead  <= memRead;
            dataWrite <= memWrite;
        end else if ((state == busPkg::reqData) && dAck) begin
            state     <= busPkg::reqFetch;
            dataRead  <= 1'b0;
            dataWrite <= 1'b0;
        end
    end

    // Address and store data stay put for the whole data access.
    always_ff @(posedge clk) begin
        if (startData) begin
            dAddress <= memAddress;
            memStore <= storeData;
        end
    end

endmodule

//--- programCounter.sv
`timescale 1ns/10ps
`include "core_params.svh"

module programCounter (
    input  logic         clk,
    input  logic         rstN,
    input  logic         commit,
    input  logic         branch,
    input  logic         branchTaken,
    input  logic         jal,
    input  logic         jalr,
    input  busPkg::wordT imm,
    input  busPkg::wordT jalrTarget,
    output busPkg::addrT pc
);

    busPkg::addrT nextPc;

    always_comb begin
        if (jalr) begin
            // JALR clears the lowest bit of the computed target.
            nextPc = {jalrTarget[`XLEN-1:1], 1'b0};
        end else if (jal || (branch && branchTaken)) begin
            nextPc = pc + imm;
        end else begin
            nextPc = pc + `XLEN'(4);
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= `RESET_PC;
        end else if (commit) begin
            pc <= nextPc;
        end
    end

endmodule

//--- alu.sv
`timescale 1ns/10ps

module alu (
    input  busPkg::wordT  srcA,
    input  busPkg::wordT  srcB,
    input  isaPkg::aluOpT aluOp,
    input  logic [2:0]    funct3,
    output busPkg::wordT  result,
    output logic          branchTaken
);

    logic equal;
    logic lessSigned;
    logic lessUnsigned;

    assign equal        = (srcA == srcB);
    assign lessSigned   = ($signed(srcA) < $signed(srcB));
    assign lessUnsigned = (srcA < srcB);

    always_comb begin
        case (aluOp)
            isaPkg::aluAdd:   result = srcA + srcB;
            isaPkg::aluSub:   result = srcA - srcB;
            isaPkg::aluSll:   result = srcA << srcB[4:0];
            isaPkg::aluSlt:   result = busPkg::wordT'(lessSigned);
            isaPkg::aluSltu:  result = busPkg::wordT'(lessUnsigned);
            isaPkg::aluXor:   result = srcA ^ srcB;
            isaPkg::aluSrl:   result = srcA >> srcB[4:0];
            isaPkg::aluSra:   result = $signed(srcA) >>> srcB[4:0];
            isaPkg::aluOr:    result = srcA | srcB;
            isaPkg::aluAnd:   result = srcA & srcB;
            isaPkg::aluPassB: result = srcB;
            default:          result = '0;
        endcase
    end

    // Branch condition from funct3, evaluated on the raw register operands.
    always_comb begin
        case (funct3)
            3'b000:  branchTaken = equal;
            3'b001:  branchTaken = !equal;
            3'b100:  branchTaken = lessSigned;
            3'b101:  branchTaken = !lessSigned;
            3'b110:  branchTaken = lessUnsigned;
            3'b111:  branchTaken = !lessUnsigned;
            default: branchTaken = 1'b0;
        endcase
    end

endmodule

//--- controlUnit.sv
`timescale 1ns/10ps

module controlUnit (
    input  isaPkg::instrT  instruction,
    output isaPkg::regIdxT readIdxA,
    output isaPkg::regIdxT readIdxB,
    output isaPkg::regIdxT writeIdx,
    output busPkg::wordT   imm,
    output isaPkg::aluOpT  aluOp,
    output logic           aluSrcImm,
    output logic           regWrite,
    output logic           memRead,
    output logic           memWrite,
    output logic           memToReg,
    output logic           branch,
    output logic           jal,
    output logic           jalr
);

    isaPkg::opcodeT opcode;
    logic [2:0]     funct3;
    logic           funct7b5;
    busPkg::wordT   immI;
    busPkg::wordT   immS;
    busPkg::wordT   immB;
    busPkg::wordT   immU;
    busPkg::wordT   immJ;

    // SUB and SRA are told apart by bit 30; for immediates only the shift uses it.
    function automatic isaPkg::aluOpT decodeAlu(
        input logic [2:0] f3,
        input logic       f7b5,
        input logic       isReg
    );
        case (f3)
            3'b000:  return (isReg && f7b5) ? isaPkg::aluSub : isaPkg::aluAdd;
            3'b001:  return isaPkg::aluSll;
            3'b010:  return isaPkg::aluSlt;
            3'b011:  return isaPkg::aluSltu;
            3'b100:  return isaPkg::aluXor;
            3'b101:  return f7b5 ? isaPkg::aluSra : isaPkg::aluSrl;
            3'b110:  return isaPkg::aluOr;
            default: return isaPkg::aluAnd;
        endcase
    endfunction

    assign opcode   = isaPkg::opcodeT'(instruction[6:0]);
    assign funct3   = instruction[14:12];
    assign funct7b5 = instruction[30];
    assign readIdxA = instruction[19:15];
    assign readIdxB = instruction[24:20];
    assign writeIdx = instruction[11:7];

    assign immI = {{20{instruction[31]}}, instruction[31:20]};
    assign immS = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign immB = {{19{instruction[31]}}, instruction[31], instruction[7],
                   instruction[30:25], instruction[11:8], 1'b0};
    assign immU = {instruction[31:12], 12'b0};
    assign immJ = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                   instruction[20], instruction[30:21], 1'b0};

    always_comb begin
        imm       = '0;
        aluOp     = isaPkg::aluAdd;
        aluSrcImm = 1'b0;
        regWrite  = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        memToReg  = 1'b0;
        branch    = 1'b0;
        jal       = 1'b0;
        jalr      = 1'b0;
        case (opcode)
            isaPkg::opLui: begin
                imm       = immU;
                aluOp     = isaPkg::aluPassB;
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
            end
            isaPkg::opJal: begin
                imm      = immJ;
                jal      = 1'b1;
                regWrite = 1'b1;
            end
            isaPkg::opJalr: begin
                // The ALU adds rs1 and the offset to form the jump target.
                imm       = immI;
                aluSrcImm = 1'b1;
                jalr      = 1'b1;
                regWrite  = 1'b1;
            end
            isaPkg::opBranch: begin
                imm    = immB;
                branch = 1'b1;
            end
            isaPkg::opLoad: begin
                imm       = immI;
                aluSrcImm = 1'b1;
                memRead   = 1'b1;
                memToReg  = 1'b1;
                regWrite  = 1'b1;
            end
            isaPkg::opStore: begin
                imm       = immS;
                aluSrcImm = 1'b1;
                memWrite  = 1'b1;
            end
            isaPkg::opImm: begin
                imm       = immI;
                aluSrcImm = 1'b1;
                aluOp     = decodeAlu(funct3, funct7b5, 1'b0);
                regWrite  = 1'b1;
            end
            isaPkg::opReg: begin
                aluOp    = decodeAlu(funct3, funct7b5, 1'b1);
                regWrite = 1'b1;
            end
            // Anything else retires as a no-op.
            default: begin
                regWrite = 1'b0;
            end
        endcase
    end

endmodule

//--- registerFile.sv
`timescale 1ns/10ps
`include "core_params.svh"

module registerFile (
    input  logic           clk,
    input  logic           rstN,
    input  logic           writeEn,
    input  isaPkg::regIdxT readIdxA,
    input  isaPkg::regIdxT readIdxB,
    input  isaPkg::regIdxT writeIdx,
    input  busPkg::wordT   writeData,
    output busPkg::wordT   readDataA,
    output busPkg::wordT   readDataB
);

    // Register 0 has no storage and always reads as zero.
    busPkg::wordT regs [1:`REG_COUNT-1];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && (writeIdx != '0)) begin
            regs[writeIdx] <= writeData;
        end
    end

    assign readDataA = (readIdxA == '0) ? '0 : regs[readIdxA];
    assign readDataB = (readIdxB == '0) ? '0 : regs[readIdxB];

endmodule

//--- busPkg.sv
`include "core_params.svh"

package busPkg;

    typedef logic [`XLEN-1:0] wordT;

    typedef logic [`XLEN-1:0] addrT;

    // The request unit either waits on a fetch or on a data access.
    typedef enum logic {
        reqFetch,
        reqData
    } reqStateT;

endpackage

//--- isaPkg.sv
package isaPkg;

    typedef logic [31:0] instrT;

    typedef logic [4:0] regIdxT;

    // Major opcodes of the supported RV32I subset.
    typedef enum logic [6:0] {
        opLui    = 7'b0110111,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opBranch = 7'b1100011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opImm    = 7'b0010011,
        opReg    = 7'b0110011
    } opcodeT;

    // Operations the ALU can perform.
    // aluPassB forwards the second operand, which LUI needs.
    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd,
        aluPassB
    } aluOpT;

endpackage

//--- core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Width of data words and byte addresses.
`define XLEN 32

// Architectural registers, including the hard-wired zero register.
`define REG_COUNT 32

// First instruction fetched after reset.
`define RESET_PC 32'h0000_0000

`endif
